//--- Makefile
BIN  := obj_dir/tb_alb
SRCS := $(filter-out +%,$(shell cat sources.f)) alb_defs.svh

.PHONY: run clean

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

$(BIN): sources.f $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/1ps \
		-f sources.f --top-module tb_alb -o tb_alb

clean:
	rm -rf obj_dir sim.log

//--- alb_aligner.sv
`include "alb_defs.svh"

module alb_aligner (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 kill_i,
  input  logic                 pc_set_i,
  input  logic [`ALB_XLEN-1:0] branch_addr_i,
  input  logic                 resp_accept_i,
  input  alb_pkg::alb_entry_t  resp_entry_i,
  input  logic                 instr_ready_i,
  alb_rd_if.aligner            rd,
  output logic                 emit_o,
  output logic                 instr_valid_o,
  output logic [`ALB_XLEN-1:0] instr_rdata_o,
  output logic                 instr_err_o,
  output logic [`ALB_XLEN-1:0] instr_addr_o
);
  import alb_pkg::*;

  // Current instruction address
  logic [`ALB_XLEN-1:0] addr_q, addr_n;
  logic [`ALB_XLEN-1:0] addr_incr;

  // Word holding the low half of the instruction
  alb_word_u aligned_word;
  logic      aligned_err;
  // Word following it, for the upper half of split instructions
  alb_word_u next_word;
  logic      next_err;
  // Instruction starting at an odd halfword
  alb_word_u split_word;
  logic      split_err;

  logic      any_valid;
  logic      split_valid;
  logic      lo_is_comp;
  logic      hi_is_comp;
  logic      word_done;

  ////////////////////////////////////////
  // Source selection
  ////////////////////////////////////////

  // Buffered data first, else the word arriving now
  assign aligned_word = rd.q0_valid ? rd.q0.word : resp_entry_i.word;
  assign aligned_err  = rd.q0_valid ? rd.q0.err  : resp_entry_i.err;
  assign next_word    = rd.q1_valid ? rd.q1.word : resp_entry_i.word;
  assign next_err     = rd.q1_valid ? rd.q1.err  : resp_entry_i.err;

  // Upper half of current word below, lower half of next word above
  assign split_word.half.lo = aligned_word.half.hi;
  assign split_word.half.hi = next_word.half.lo;

  assign lo_is_comp = (aligned_word.half.lo[1:0] != `ALB_UNCOMP);
  assign hi_is_comp = (aligned_word.half.hi[1:0] != `ALB_UNCOMP);

  // Second word only counts when the instruction reaches into it
  assign split_err = aligned_err | (!hi_is_comp & next_err);

  assign any_valid   = rd.q0_valid || resp_accept_i;
  // q1 valid implies q0 valid
  assign split_valid = rd.q1_valid || (rd.q0_valid && resp_accept_i);

  ////////////////////////////////////////
  // Decode side outputs
  ////////////////////////////////////////

  assign instr_rdata_o = addr_q[1] ? split_word.instr : aligned_word.instr;
  assign instr_err_o   = addr_q[1] ? split_err : aligned_err;
  assign instr_addr_o  = addr_q;

  always_comb begin
    if (kill_i) begin
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      // Odd halfword, uncompressed needs the following word too
      instr_valid_o = any_valid && (hi_is_comp || split_valid);
    end else begin
      instr_valid_o = any_valid;
    end
  end

  assign emit_o = instr_valid_o && instr_ready_i;

  ////////////////////////////////////////
  // Address and buffer advance
  ////////////////////////////////////////

  assign addr_incr = {addr_q[`ALB_XLEN-1:2], 2'b00} + `ALB_XLEN'(4);

  // Current word is used up unless an aligned compressed leaves its upper half
  assign word_done = addr_q[1] || !lo_is_comp;

  always_comb begin
    if (addr_q[1]) begin
      // Split uncompressed ends halfway into the next word
      addr_n = {addr_incr[`ALB_XLEN-1:2], !hi_is_comp, 1'b0};
    end else if (lo_is_comp) begin
      addr_n = {addr_q[`ALB_XLEN-1:2], 2'b10};
    end else begin
      addr_n = addr_incr;
    end
  end

  assign rd.adv    = emit_o && word_done;
  assign rd.clr_q0 = emit_o && word_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (pc_set_i) begin
      // First word received after a branch belongs to this address
      addr_q <= branch_addr_i;
    end else if (emit_o) begin
      addr_q <= addr_n;
    end
  end

endmodule

//--- alb_checker.sv
`include "alb_defs.svh"

module alb_checker (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 kill_i,
  input logic                 fetch_valid_o,
  input logic                 fetch_ready_i,
  input logic                 resp_valid_i,
  input logic                 instr_valid_o,
  input logic                 instr_ready_i,
  input logic [`ALB_XLEN-1:0] instr_rdata_o,
  input logic [`ALB_XLEN-1:0] instr_addr_o,
  input logic                 busy_o,
  input logic                 protocol_err_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions, read by the testbench at the end
  int       fail_cnt = 0;
  // Fetches in flight, seen from the ports
  logic [2:0] outstnd_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstnd_q <= '0;
    end else begin
      outstnd_q <= outstnd_q + 3'(fetch_valid_o && fetch_ready_i)
                   - 3'(resp_valid_i && (outstnd_q != '0));
    end
  end

  ////////////////////////////////////////
  // Reset and kill
  ////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !fetch_valid_o && !instr_valid_o && !busy_o && !protocol_err_o)
    else begin $error("outputs active during reset"); fail_cnt++; end

  a_kill_blocks: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> !instr_valid_o)
    else begin $error("instr_valid_o high during kill"); fail_cnt++; end

  ////////////////////////////////////////
  // Decode side hold under back-pressure
  ////////////////////////////////////////

  // Upper half of a compressed instruction is don't-care
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_o && !instr_ready_i && !kill_i) |=>
      kill_i || (instr_valid_o && $stable(instr_addr_o) &&
                 $stable(instr_rdata_o[15:0]) &&
                 ((instr_rdata_o[1:0] != `ALB_UNCOMP) || $stable(instr_rdata_o))))
    else begin $error("instruction changed while stalled"); fail_cnt++; end

  ////////////////////////////////////////
  // Fetch accounting
  ////////////////////////////////////////

  a_outstnd_max: assert property (@(posedge clk) disable iff (!rst_n)
    outstnd_q <= 3'(`ALB_OUTSTND_MAX))
    else begin $error("more than two fetches outstanding"); fail_cnt++; end

  a_protocol: assert property (@(posedge clk) disable iff (!rst_n)
    protocol_err_o == (resp_valid_i && (outstnd_q == '0)))
    else begin $error("protocol_err_o wrong"); fail_cnt++; end

endmodule

bind alb_top alb_checker chk_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .kill_i         (kill_i),
  .fetch_valid_o  (fetch_valid_o),
  .fetch_ready_i  (fetch_ready_i),
  .resp_valid_i   (resp_valid_i),
  .instr_valid_o  (instr_valid_o),
  .instr_ready_i  (instr_ready_i),
  .instr_rdata_o  (instr_rdata_o),
  .instr_addr_o   (instr_addr_o),
  .busy_o         (busy_o),
  .protocol_err_o (protocol_err_o)
);

//--- alb_ctrl.sv
`include "alb_defs.svh"

module alb_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_req_i,
  input  logic                 kill_i,
  input  logic                 pc_set_i,
  input  logic [`ALB_XLEN-1:0] branch_addr_i,
  input  logic                 fetch_ready_i,
  input  logic                 resp_valid_i,
  input  alb_pkg::alb_word_u   resp_word_i,
  input  logic                 emit_i,
  output logic                 fetch_valid_o,
  output logic                 resp_accept_o,
  output logic                 busy_o,
  output logic                 protocol_err_o
);

  localparam int unsigned OUT_W = $clog2(`ALB_OUTSTND_MAX + 1);
  localparam int unsigned CNT_W = `ALB_CNT_W;

  // Fetches in flight and stale responses still to drop
  logic [OUT_W-1:0] outstnd_q, outstnd_n;
  logic [OUT_W-1:0] flush_q, flush_n;
  logic             cnt_up, cnt_down;

  // Complete instructions held in the buffer
  logic [CNT_W-1:0] instr_cnt_q, instr_cnt_n;
  logic [CNT_W-1:0] cnt_minus_pop;
  // Emission seen last cycle
  logic             pop_q;

  // Write-side tracker
  logic             aligned_q, aligned_n;
  logic             complete_q, complete_n;
  logic [1:0]       n_incoming;
  logic             lo_uncomp, hi_uncomp;

  ////////////////////////////////////////
  // Fetch request
  ////////////////////////////////////////

  assign cnt_minus_pop = instr_cnt_q - CNT_W'(pop_q);

  // Ask for a word when the buffer runs dry or on a branch
  assign fetch_valid_o = instr_req_i &&
                         (outstnd_q < OUT_W'(`ALB_OUTSTND_MAX)) &&
                         (pc_set_i ||
                          (cnt_minus_pop == '0) ||
                          ((cnt_minus_pop == CNT_W'(1)) && (outstnd_q == '0)));

  assign busy_o = (outstnd_q != '0) || fetch_valid_o;

  // Response with no fetch in flight
  assign protocol_err_o = resp_valid_i && (outstnd_q == '0);

  // Responses are dropped while the flush count is nonzero
  assign resp_accept_o = resp_valid_i && (flush_q == '0);

  ////////////////////////////////////////
  // Outstanding and flush counters
  ////////////////////////////////////////

  assign cnt_up   = fetch_valid_o && fetch_ready_i;
  // Spurious responses leave the count alone
  assign cnt_down = resp_valid_i && (outstnd_q != '0);

  always_comb begin
    outstnd_n = outstnd_q;
    if (cnt_up && !cnt_down) begin
      outstnd_n = outstnd_q + OUT_W'(1);
    end else if (!cnt_up && cnt_down) begin
      outstnd_n = outstnd_q - OUT_W'(1);
    end
  end

  always_comb begin
    flush_n = flush_q;
    if (pc_set_i) begin
      // Every fetch in flight is stale, minus the one landing now
      flush_n = cnt_down ? (outstnd_q - OUT_W'(1)) : outstnd_q;
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_n = flush_q - OUT_W'(1);
    end
  end

  ////////////////////////////////////////
  // Instruction tracker
  ////////////////////////////////////////

  assign lo_uncomp = (resp_word_i.half.lo[1:0] == `ALB_UNCOMP);
  assign hi_uncomp = (resp_word_i.half.hi[1:0] == `ALB_UNCOMP);

  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = 2'd0;
    if (pc_set_i) begin
      // Odd-halfword target, low half of first word is skipped
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_accept_o) begin
      if (aligned_q && lo_uncomp) begin
        // Whole word is one instruction, state unchanged
        n_incoming = 2'd1;
      end else if (aligned_q || !complete_q) begin
        // Low half closes an instruction, upper half decides the rest
        n_incoming = hi_uncomp ? 2'd1 : 2'd2;
        aligned_n  = !hi_uncomp;
        complete_n = !hi_uncomp;
      end else begin
        // First word after an odd target
        n_incoming = hi_uncomp ? 2'd0 : 2'd1;
        aligned_n  = !hi_uncomp;
        complete_n = !hi_uncomp;
      end
    end
  end

  // Emissions are subtracted one cycle late
  always_comb begin
    if (kill_i) begin
      instr_cnt_n = '0;
    end else begin
      instr_cnt_n = instr_cnt_q + CNT_W'(n_incoming) - CNT_W'(pop_q);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstnd_q   <= '0;
      flush_q     <= '0;
      instr_cnt_q <= '0;
      pop_q       <= 1'b0;
      aligned_q   <= 1'b0;
      complete_q  <= 1'b0;
    end else begin
      outstnd_q   <= outstnd_n;
      flush_q     <= flush_n;
      instr_cnt_q <= instr_cnt_n;
      pop_q       <= emit_i;
      aligned_q   <= aligned_n;
      complete_q  <= complete_n;
    end
  end

endmodule

//--- alb_defs.svh
`ifndef ALB_DEFS_SVH
`define ALB_DEFS_SVH

////////////////////////////////////////
// Buffer geometry
////////////////////////////////////////

// Response ring buffer entries
`define ALB_DEPTH 3
// Read and write pointer width
`define ALB_PTR_W 2
// Instruction counter width, up to two instructions per entry
`define ALB_CNT_W 3
// Fetches allowed in flight
`define ALB_OUTSTND_MAX 2

////////////////////////////////////////
// Data widths and encodings
////////////////////////////////////////

`define ALB_XLEN 32
`define ALB_HALF_W 16
// Low opcode bits of a 32-bit instruction
`define ALB_UNCOMP 2'b11

`endif

//--- alb_fifo.sv
`include "alb_defs.svh"

module alb_fifo (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                kill_i,
  input  logic                pc_set_i,
  input  logic                resp_accept_i,
  input  alb_pkg::alb_entry_t resp_entry_i,
  alb_rd_if.fifo              rd
);
  import alb_pkg::*;

  localparam int unsigned DEPTH = `ALB_DEPTH;
  localparam int unsigned PTR_W = `ALB_PTR_W;

  // Entry storage
  alb_entry_t        mem [DEPTH];
  logic [DEPTH-1:0]  valid_q, valid_n;
  logic [PTR_W-1:0]  wptr_q;
  logic [PTR_W-1:0]  rptr_q;
  logic [PTR_W-1:0]  rptr_nxt;

  // Ring increment
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    logic [PTR_W-1:0] n;
    if (p == PTR_W'(DEPTH - 1)) begin
      n = '0;
    end else begin
      n = p + PTR_W'(1);
    end
    return n;
  endfunction

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  assign rptr_nxt    = next_ptr(rptr_q);
  assign rd.q0       = mem[rptr_q];
  assign rd.q1       = mem[rptr_nxt];
  assign rd.q0_valid = valid_q[rptr_q];
  assign rd.q1_valid = valid_q[rptr_nxt];

  ////////////////////////////////////////
  // Valid bits and pointers
  ////////////////////////////////////////

  // Release wins over a same-entry write, which covers a word
  // consumed straight from the bus
  always_comb begin
    valid_n = valid_q;
    if (resp_accept_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (rd.clr_q0) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      if (kill_i) begin
        valid_q <= '0;
      end else begin
        valid_q <= valid_n;
      end
      if (pc_set_i) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (resp_accept_i) begin
          wptr_q <= next_ptr(wptr_q);
        end
        if (rd.adv) begin
          rptr_q <= rptr_nxt;
        end
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (resp_accept_i && !kill_i) begin
      mem[wptr_q] <= resp_entry_i;
    end
  end

endmodule

//--- alb_pkg.sv
`include "alb_defs.svh"

package alb_pkg;

  ////////////////////////////////////////
  // Fetch word
  ////////////////////////////////////////

  // Two halfwords, upper one first
  typedef struct packed {
    logic [`ALB_HALF_W-1:0] hi;
    logic [`ALB_HALF_W-1:0] lo;
  } alb_half_pair_t;

  // One 32-bit fetch word, read either as a full instruction
  // or as two halfwords for compressed and split instructions
  typedef union packed {
    logic [`ALB_XLEN-1:0] instr;
    alb_half_pair_t       half;
  } alb_word_u;

  ////////////////////////////////////////
  // Buffer entry
  ////////////////////////////////////////

  // Stored response: fetch word plus its bus error
  typedef struct packed {
    alb_word_u word;
    logic      err;
  } alb_entry_t;

endpackage

//--- alb_rd_if.sv
// Read side of the response buffer
// The buffer presents its two oldest entries, the aligner consumes them
interface alb_rd_if;
  import alb_pkg::*;

  // Entry at the read pointer
  alb_entry_t q0;
  // Entry after the read pointer
  alb_entry_t q1;
  logic       q0_valid;
  logic       q1_valid;

  // Move the read pointer one entry forward
  logic       adv;
  // Release the entry at the read pointer
  logic       clr_q0;

  modport fifo (
    output q0,
    output q1,
    output q0_valid,
    output q1_valid,
    input  adv,
    input  clr_q0
  );

  modport aligner (
    input  q0,
    input  q1,
    input  q0_valid,
    input  q1_valid,
    output adv,
    output clr_q0
  );

endinterface

//--- alb_top.sv
`include "alb_defs.svh"

module alb_top (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core controller
  input  logic                 instr_req_i,
  input  logic                 kill_i,
  input  logic                 pc_set_i,
  input  logic [`ALB_XLEN-1:0] branch_addr_i,

  // Prefetch request
  output logic                 fetch_valid_o,
  input  logic                 fetch_ready_i,

  // Prefetch response, no back-pressure
  input  logic                 resp_valid_i,
  input  logic [`ALB_XLEN-1:0] resp_rdata_i,
  input  logic                 resp_err_i,

  // Decode side
  output logic                 instr_valid_o,
  input  logic                 instr_ready_i,
  output logic [`ALB_XLEN-1:0] instr_rdata_o,
  output logic [`ALB_XLEN-1:0] instr_addr_o,
  output logic                 instr_err_o,

  // Status
  output logic                 busy_o,
  output logic                 protocol_err_o
);
  import alb_pkg::*;

  alb_entry_t resp_entry;
  logic       resp_accept;
  logic       emit;

  // Buffer to aligner read port
  alb_rd_if rd_if ();

  assign resp_entry.word.instr = resp_rdata_i;
  assign resp_entry.err        = resp_err_i;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  alb_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_req_i    (instr_req_i),
    .kill_i         (kill_i),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr_i),
    .fetch_ready_i  (fetch_ready_i),
    .resp_valid_i   (resp_valid_i),
    .resp_word_i    (resp_entry.word),
    .emit_i         (emit),
    .fetch_valid_o  (fetch_valid_o),
    .resp_accept_o  (resp_accept),
    .busy_o         (busy_o),
    .protocol_err_o (protocol_err_o)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  alb_fifo u_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .kill_i        (kill_i),
    .pc_set_i      (pc_set_i),
    .resp_accept_i (resp_accept),
    .resp_entry_i  (resp_entry),
    .rd            (rd_if.fifo)
  );

  alb_aligner u_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .kill_i        (kill_i),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr_i),
    .resp_accept_i (resp_accept),
    .resp_entry_i  (resp_entry),
    .instr_ready_i (instr_ready_i),
    .rd            (rd_if.aligner),
    .emit_o        (emit),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .instr_addr_o  (instr_addr_o)
  );

endmodule

//--- sources.f
+incdir+.
alb_pkg.sv
alb_rd_if.sv
alb_ctrl.sv
alb_fifo.sv
alb_aligner.sv
alb_top.sv
alb_checker.sv
tb_alb.sv

//--- tb_alb.sv
`include "alb_defs.svh"

module tb_alb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYC  = 8;
  localparam int STREAM_CYC = 3000;
  localparam int FLUSH_CYC  = 1500;
  localparam int DRAIN_CYC  = 100;
  localparam int SPUR_CYC   = 4;
  localparam int TOTAL_CYC  = RESET_CYC + STREAM_CYC + FLUSH_CYC + DRAIN_CYC + SPUR_CYC;

  logic        clk = 1'b0;
  logic        rst_n, instr_req_i, kill_i, pc_set_i, fetch_ready_i, instr_ready_i;
  logic [31:0] branch_addr_i;
  logic        resp_valid_i = 1'b0;
  logic [31:0] resp_rdata_i = '0;
  logic        resp_err_i = 1'b0;
  logic        fetch_valid_o, instr_valid_o, instr_err_o, busy_o, protocol_err_o;
  logic [31:0] instr_rdata_o, instr_addr_o;

  // Prefetch model state
  logic [29:0] pend_addr[$];
  int          pend_due[$];
  logic [29:0] next_word = '0;
  int          cyc = 0;
  logic        spur_req = 1'b0;

  // Expected-stream state and counters
  logic [31:0] exp_addr = '0;
  logic        after_branch = 1'b0;
  int          checked = 0;
  int          errors = 0;
  int          first_even = 0;
  int          first_odd = 0;
  int          prot_seen = 0;
  logic [15:0] lfsr = 16'd14222;

  alb_top dut_i (.*);

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Random source and memory image
  ////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  // Halfword by halfword index, opcode bits picked from the index
  function automatic logic [15:0] half_at(input logic [31:0] h);
    logic [15:0] body;
    logic [1:0]  op;
    body = (h[15:0] * 16'h6b3d) ^ h[31:16] ^ 16'h5a17;
    if (h[2] ^ h[4]) op = 2'b11;
    else op = h[3] ? 2'b10 : {1'b0, h[0]};
    return {body[15:2], op};
  endfunction

  // Byte address bit 5 marks an erroring word
  function automatic logic err_at(input logic [31:0] w);
    return w[3];
  endfunction

  ////////////////////////////////////////
  // Prefetch responses
  ////////////////////////////////////////

  always @(posedge clk) begin
    cyc++;
    if (spur_req) begin
      resp_valid_i <= 1'b1;
      resp_rdata_i <= {half_at(32'd1), half_at(32'd0)};
      resp_err_i   <= 1'b0;
      spur_req = 1'b0;
    end else if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
      resp_valid_i <= 1'b1;
      resp_rdata_i <= {half_at({1'b0, pend_addr[0], 1'b1}), half_at({1'b0, pend_addr[0], 1'b0})};
      resp_err_i   <= err_at({2'b00, pend_addr[0]});
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end else begin
      resp_valid_i <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Monitor, sampled mid-cycle
  ////////////////////////////////////////

  task automatic check_instr();
    logic [31:0] h;
    logic [15:0] lo;
    logic [31:0] exp_data;
    logic        exp_err;
    logic        comp;
    h  = {1'b0, exp_addr[31:1]};
    lo = half_at(h);
    comp = (lo[1:0] != `ALB_UNCOMP);
    exp_data = {half_at(h + 1), lo};
    exp_err  = err_at(h >> 1) | (!comp & err_at((h + 1) >> 1));
    if (instr_addr_o !== exp_addr) begin
      $display("ERROR %0t: addr %h, expected %h", $time, instr_addr_o, exp_addr);
      errors++;
    end else if (comp ? (instr_rdata_o[15:0] !== lo) : (instr_rdata_o !== exp_data)) begin
      $display("ERROR %0t: data %h at %h, expected %h", $time, instr_rdata_o, exp_addr, exp_data);
      errors++;
    end else if (instr_err_o !== exp_err) begin
      $display("ERROR %0t: err %b at %h, expected %b", $time, instr_err_o, exp_addr, exp_err);
      errors++;
    end
    if (after_branch) begin
      if (exp_addr[1]) first_odd++;
      else first_even++;
    end
    after_branch = 1'b0;
    checked++;
    exp_addr = exp_addr + (comp ? 32'd2 : 32'd4);
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (protocol_err_o) prot_seen++;
      // Branch restarts both the fetch stream and the reference walk
      if (pc_set_i) begin
        exp_addr     = branch_addr_i;
        next_word    = branch_addr_i[31:2];
        after_branch = 1'b1;
      end
      if (fetch_valid_o && fetch_ready_i) begin
        pend_addr.push_back(next_word);
        pend_due.push_back(cyc + 1 + int'(take_bits(1)));
        next_word++;
      end
      if (instr_valid_o && instr_ready_i) check_instr();
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic run_phase(input string name, input int ncyc, input bit full_fetch,
                           input int br_bits);
    int   chk0;
    int   err0;
    logic do_br;
    chk0 = checked;
    err0 = errors;
    for (int i = 0; i < ncyc; i++) begin
      @(posedge clk);
      do_br = (i == 0) || (!pc_set_i && take_bits(br_bits) == 0);
      instr_req_i   <= 1'b1;
      kill_i        <= do_br;
      pc_set_i      <= do_br;
      branch_addr_i <= 32'h200 + {15'd0, take_bits(8), 1'b0};
      fetch_ready_i <= full_fetch ? 1'b1 : take_bits(1) != 0;
      instr_ready_i <= take_bits(2) != 0;
    end
    $display("test %s: %0d instructions, %0d errors", name, checked - chk0, errors - err0);
  endtask

  initial begin
    int n;
    int prot0;
    rst_n = 1'b0;
    instr_req_i = 1'b0;
    kill_i = 1'b0;
    pc_set_i = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b0;
    instr_ready_i = 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    rst_n <= 1'b1;
    $display("test reset: released after %0d cycles", RESET_CYC);

    run_phase("stream", STREAM_CYC, 1'b0, 4);
    run_phase("branch_flush", FLUSH_CYC, 1'b1, 2);
    if (first_even == 0 || first_odd == 0) begin
      $display("branch targets did not reach both even and odd halfwords");
      errors++;
    end
    $display("test branch_targets: %0d even, %0d odd", first_even, first_odd);

    // Drain fetches and buffered instructions, decode keeps accepting
    @(posedge clk);
    instr_req_i   <= 1'b0;
    instr_ready_i <= 1'b1;
    kill_i        <= 1'b0;
    pc_set_i      <= 1'b0;
    fetch_ready_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (n < DRAIN_CYC && (busy_o || pend_addr.size() != 0 || resp_valid_i ||
                                 instr_valid_o));
    if (n >= DRAIN_CYC) begin
      $display("drain did not finish, fetches or instructions still pending");
      errors++;
    end
    if (prot_seen != 0) begin
      $display("ERROR %0t: %0d protocol errors during normal traffic", $time, prot_seen);
      errors++;
    end

    // Stall decode, then one response with nothing outstanding
    @(posedge clk);
    instr_ready_i <= 1'b0;
    @(negedge clk);
    prot0 = prot_seen;
    spur_req = 1'b1;
    repeat (SPUR_CYC) @(negedge clk);
    if (prot_seen - prot0 != 1) begin
      $display("ERROR %0t: spurious response gave %0d protocol errors", $time,
               prot_seen - prot0);
      errors++;
    end
    $display("test spurious: %0d protocol errors", prot_seen - prot0);

    $display("tests 5, instructions %0d, errors %0d, assertion failures %0d",
             checked, errors, dut_i.chk_i.fail_cnt);
    if (errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog over the whole test length
  initial begin
    #(TOTAL_CYC * 10 + 1000);
    $display("watchdog expired, run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule
